/* bench/tb_simple_dma.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_simple_dma import dma_pkg::*;
();

  localparam int FIFO_DEPTH  = 16;
  localparam int CLK_PERIOD  = 10;
  // every word moved by every transfer below
  localparam int TOTAL_WORDS = 8 + 40 + 8 + 8 + 4;
  localparam int WDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

  logic                Bus2IP_Clk;
  logic                arst_n;
  logic [DATA_W-1:0]   bus2ip_data;
  logic [NUM_REGS-1:0] bus2ip_wrce;
  logic [NUM_REGS-1:0] bus2ip_rdce;
  logic [DATA_W-1:0]   ip2bus_data;
  logic                ip2bus_wrack;
  logic                ip2bus_rdack;
  logic                ip2bus_mstrd_req;
  logic                ip2bus_mstwr_req;
  logic [ADDR_W-1:0]   ip2bus_mst_addr;
  logic                bus2ip_mst_cmdack;
  logic                bus2ip_mst_cmplt;
  logic                bus2ip_mst_error;
  logic                bus2ip_mst_cmd_timeout;
  logic [DATA_W-1:0]   bus2ip_mstrd_d;
  logic                bus2ip_mstrd_src_rdy_n;
  logic                bus2ip_mstwr_dst_rdy_n;
  logic [DATA_W-1:0]   ip2bus_mstwr_d;
  logic                irq;

  // scoreboard state shared by the processes
  int unsigned       errors;
  int unsigned       irq_count;
  int unsigned       irq_expected;
  int unsigned       rd_index;
  int unsigned       wr_index;
  int unsigned       rd_run;
  int unsigned       total_writes;
  logic [ADDR_W-1:0] exp_src;
  logic [ADDR_W-1:0] exp_dst;
  logic [ADDR_W-1:0] cur_addr;
  // 0 none, 1 error, 2 timeout
  int                fault_kind;
  // 1-based read command that gets the fault
  int unsigned       fault_read;

  simple_dma #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .Bus2IP_Clk             (Bus2IP_Clk),
    .arst_n                 (arst_n),
    .bus2ip_data            (bus2ip_data),
    .bus2ip_wrce            (bus2ip_wrce),
    .bus2ip_rdce            (bus2ip_rdce),
    .ip2bus_data            (ip2bus_data),
    .ip2bus_wrack           (ip2bus_wrack),
    .ip2bus_rdack           (ip2bus_rdack),
    .ip2bus_mstrd_req       (ip2bus_mstrd_req),
    .ip2bus_mstwr_req       (ip2bus_mstwr_req),
    .ip2bus_mst_addr        (ip2bus_mst_addr),
    .bus2ip_mst_cmdack      (bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt       (bus2ip_mst_cmplt),
    .bus2ip_mst_error       (bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout (bus2ip_mst_cmd_timeout),
    .bus2ip_mstrd_d         (bus2ip_mstrd_d),
    .bus2ip_mstrd_src_rdy_n (bus2ip_mstrd_src_rdy_n),
    .bus2ip_mstwr_dst_rdy_n (bus2ip_mstwr_dst_rdy_n),
    .ip2bus_mstwr_d         (ip2bus_mstwr_d),
    .irq                    (irq)
  );

  initial
  begin
    Bus2IP_Clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) Bus2IP_Clk = ~Bus2IP_Clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // memory contents, odd multiplier keeps every address distinct
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    mem_word = (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [DATA_W-1:0] status_word(input logic busy, input logic done,
                                                    input logic err, input logic tmo,
                                                    input logic empty, input logic full);
    status_word                = '0;
    status_word[ST_BUSY]       = busy;
    status_word[ST_DONE]       = done;
    status_word[ST_ERROR]      = err;
    status_word[ST_TIMEOUT]    = tmo;
    status_word[ST_FIFO_EMPTY] = empty;
    status_word[ST_FIFO_FULL]  = full;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // ------------------------------
  // register bus
  // ------------------------------
  task automatic reg_write(input int idx, input logic [DATA_W-1:0] val);
    logic [NUM_REGS-1:0] ce;
    ce                 = '0;
    // register 0 sits on the top enable bit
    ce[NUM_REGS-1-idx] = 1'b1;
    @(posedge Bus2IP_Clk);
    bus2ip_wrce <= ce;
    bus2ip_data <= val;
    @(negedge Bus2IP_Clk);
    if (ip2bus_wrack !== 1'b1)
      report_mismatch("ip2bus_wrack", 32'd1, 32'(ip2bus_wrack));
    @(posedge Bus2IP_Clk);
    bus2ip_wrce <= '0;
  endtask

  task automatic reg_read(input int idx, output logic [DATA_W-1:0] data);
    logic [NUM_REGS-1:0] ce;
    ce                 = '0;
    ce[NUM_REGS-1-idx] = 1'b1;
    @(posedge Bus2IP_Clk);
    bus2ip_rdce <= ce;
    @(negedge Bus2IP_Clk);
    data = ip2bus_data;
    if (ip2bus_rdack !== 1'b1)
      report_mismatch("ip2bus_rdack", 32'd1, 32'(ip2bus_rdack));
    @(posedge Bus2IP_Clk);
    bus2ip_rdce <= '0;
  endtask

  // program one transfer, fire go and wait for the irq
  task automatic run_transfer(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                              input int unsigned words);
    exp_src  = src;
    exp_dst  = dst;
    rd_index = 0;
    wr_index = 0;
    rd_run   = 0;
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_LEN, DATA_W'(words * WORD_BYTES));
    reg_write(REG_GO, GO_KEY);
    irq_expected++;
    @(negedge Bus2IP_Clk);
    while (irq !== 1'b1)
      @(negedge Bus2IP_Clk);
    // room for a stray second pulse to show up
    repeat (6) @(posedge Bus2IP_Clk);
    if (irq_count != irq_expected)
      report_mismatch("irq pulse count", irq_expected, irq_count);
  endtask

  // expected end state, words written and status
  task automatic check_end(input int unsigned writes, input logic [DATA_W-1:0] exp_status,
                           input logic [DATA_W-1:0] exp_remain);
    logic [DATA_W-1:0] rdata;
    if (wr_index != writes)
      report_mismatch("write count", writes, wr_index);
    reg_read(REG_STATUS, rdata);
    if (rdata !== exp_status)
      report_mismatch("status", exp_status, rdata);
    reg_read(REG_REMAIN, rdata);
    if (rdata !== exp_remain)
      report_mismatch("remain", exp_remain, rdata);
  endtask

  // ------------------------------
  // master bus responder
  // ------------------------------
  initial
  begin : responder
    int unsigned delay;
    logic        is_wr;
    logic        bad;
    // fixed seed for the response delays
    void'($urandom(32'hc7ce_8298));
    forever
    begin
      @(negedge Bus2IP_Clk);
      if (ip2bus_mstrd_req === 1'b1 || ip2bus_mstwr_req === 1'b1)
      begin
        is_wr    = ip2bus_mstwr_req;
        cur_addr = ip2bus_mst_addr;
        delay    = 1 + ($urandom % 4);
        repeat (delay) @(posedge Bus2IP_Clk);
        bus2ip_mst_cmdack <= 1'b1;
        @(posedge Bus2IP_Clk);
        bus2ip_mst_cmdack <= 1'b0;
        bus2ip_mst_cmplt  <= 1'b1;
        bad = !is_wr && (fault_kind != 0) && (rd_index == fault_read);
        // data beat rides with cmplt, none on a faulted read
        if (bad)
        begin
          bus2ip_mst_error       <= (fault_kind == 1);
          bus2ip_mst_cmd_timeout <= (fault_kind == 2);
        end
        else if (is_wr)
          bus2ip_mstwr_dst_rdy_n <= 1'b0;
        else
        begin
          bus2ip_mstrd_d         <= mem_word(cur_addr);
          bus2ip_mstrd_src_rdy_n <= 1'b0;
        end
        @(posedge Bus2IP_Clk);
        bus2ip_mst_cmplt       <= 1'b0;
        bus2ip_mst_error       <= 1'b0;
        bus2ip_mst_cmd_timeout <= 1'b0;
        bus2ip_mstrd_src_rdy_n <= 1'b1;
        bus2ip_mstwr_dst_rdy_n <= 1'b1;
      end
    end
  end

  // ------------------------------
  // checker
  // ------------------------------
  initial
  begin : bus_monitor
    logic rd_req_q;
    logic wr_req_q;
    logic irq_q;
    rd_req_q = 1'b0;
    wr_req_q = 1'b0;
    irq_q    = 1'b0;
    forever
    begin
      @(negedge Bus2IP_Clk);
      if (arst_n === 1'b1)
      begin
        // each request counted on its first cycle
        if (ip2bus_mstrd_req && !rd_req_q)
        begin
          if (ip2bus_mst_addr !== exp_src + ADDR_W'(WORD_BYTES * rd_index))
            report_mismatch("ip2bus_mst_addr (read)",
                            exp_src + ADDR_W'(WORD_BYTES * rd_index), ip2bus_mst_addr);
          rd_index++;
          rd_run++;
          if (rd_run > FIFO_DEPTH)
            report_error("more reads in a row than the FIFO can hold");
        end
        if (ip2bus_mstwr_req && !wr_req_q)
          rd_run = 0;
        // destination write completes with the pop
        if (bus2ip_mst_cmplt && !bus2ip_mstwr_dst_rdy_n)
        begin
          if (cur_addr !== exp_dst + ADDR_W'(WORD_BYTES * wr_index))
            report_mismatch("ip2bus_mst_addr (write)",
                            exp_dst + ADDR_W'(WORD_BYTES * wr_index), cur_addr);
          if (ip2bus_mstwr_d !== mem_word(exp_src + ADDR_W'(WORD_BYTES * wr_index)))
            report_mismatch("ip2bus_mstwr_d",
                            mem_word(exp_src + ADDR_W'(WORD_BYTES * wr_index)), ip2bus_mstwr_d);
          wr_index++;
          total_writes++;
        end
        if (irq)
        begin
          if (irq_q)
            report_error("irq stayed high for more than one cycle");
          else
            irq_count++;
        end
        rd_req_q = ip2bus_mstrd_req;
        wr_req_q = ip2bus_mstwr_req;
        irq_q    = irq;
      end
    end
  end

  initial
  begin : watchdog
    repeat (WDOG_CYCLES) @(posedge Bus2IP_Clk);
    $display("ERROR t=%0t watchdog expired before the tests finished", $time);
    $display("errors: %0d, writes checked: %0d", errors + 1, total_writes);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin : main
    logic [DATA_W-1:0] rdata;
    errors                 = 0;
    irq_count              = 0;
    irq_expected           = 0;
    rd_index               = 0;
    wr_index               = 0;
    rd_run                 = 0;
    total_writes           = 0;
    exp_src                = '0;
    exp_dst                = '0;
    cur_addr               = '0;
    fault_kind             = 0;
    fault_read             = 0;
    arst_n                 = 1'b0;
    bus2ip_data            = '0;
    bus2ip_wrce            = '0;
    bus2ip_rdce            = '0;
    bus2ip_mst_cmdack      = 1'b0;
    bus2ip_mst_cmplt       = 1'b0;
    bus2ip_mst_error       = 1'b0;
    bus2ip_mst_cmd_timeout = 1'b0;
    bus2ip_mstrd_d         = '0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    repeat (4) @(posedge Bus2IP_Clk);
    arst_n <= 1'b1;
    @(negedge Bus2IP_Clk);
    if (irq !== 1'b0 || ip2bus_mstrd_req !== 1'b0 || ip2bus_mstwr_req !== 1'b0)
      report_error("control outputs not low after reset");
    reg_read(REG_STATUS, rdata);
    if (rdata !== status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0))
      report_mismatch("status", status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0), rdata);

    // register readback
    reg_write(REG_SRC, 32'h1000_0040);
    reg_write(REG_DST, 32'h2000_0800);
    reg_write(REG_LEN, 32'h0000_0124);
    reg_read(REG_SRC, rdata);
    if (rdata !== 32'h1000_0040)
      report_mismatch("src_addr", 32'h1000_0040, rdata);
    reg_read(REG_DST, rdata);
    if (rdata !== 32'h2000_0800)
      report_mismatch("dst_addr", 32'h2000_0800, rdata);
    reg_read(REG_LEN, rdata);
    if (rdata !== 32'h0000_0124)
      report_mismatch("len_bytes", 32'h0000_0124, rdata);

    // short and long transfers
    run_transfer(32'h1000_0000, 32'h2000_0000, 8);
    check_end(8, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), '0);
    run_transfer(32'h1003_0400, 32'h2004_1000, 40);
    check_end(40, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), '0);

    // error then timeout on the third read, two reads land first
    fault_kind = 1;
    fault_read = 3;
    run_transfer(32'h1100_0000, 32'h2100_0000, 8);
    check_end(0, status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0), 32'd24);
    fault_kind = 2;
    run_transfer(32'h1200_0000, 32'h2200_0000, 8);
    check_end(0, status_word(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0), 32'd24);
    fault_kind = 0;
    run_transfer(32'h1300_0010, 32'h2300_0020, 4);
    check_end(4, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), '0);

    // wrong key does nothing, and go holds no value
    rd_index = 0;
    wr_index = 0;
    reg_write(REG_LEN, 32'd16);
    reg_write(REG_GO, 32'h0000_0055);
    reg_read(REG_GO, rdata);
    if (rdata !== '0)
      report_mismatch("go register", 32'h0, rdata);
    repeat (20) @(posedge Bus2IP_Clk);
    if (rd_index != 0 || wr_index != 0)
      report_error("request issued after a go write without the key");
    if (irq_count != irq_expected)
      report_mismatch("irq pulse count", irq_expected, irq_count);
    // zero length finishes without a command
    run_transfer(32'h1400_0000, 32'h2400_0000, 0);
    if (rd_index != 0)
      report_error("request issued for a zero length transfer");
    check_end(0, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), '0);

    repeat (5) @(posedge Bus2IP_Clk);
    $display("errors: %0d, writes checked: %0d", errors, total_writes);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/dma_pkg.sv
hw/dma_regs.sv
hw/dma_sequencer.sv
hw/mst_cmd_fsm.sv
hw/data_fifo.sv
hw/simple_dma.sv
bench/tb_simple_dma.sv

/* hw/data_fifo.sv */
`default_nettype none
`timescale 1ns/10ps

module data_fifo import dma_pkg::*;
#(
  parameter int DEPTH = 16,
  parameter int WIDTH = DATA_W
)
(
  input  logic             Bus2IP_Clk,
  input  logic             arst_n,
  input  logic             flush,
  input  logic             push_n,
  input  logic [WIDTH-1:0] din,
  input  logic             pop_n,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // strobes are active low on the bus side
  assign push  = !push_n && !full;
  assign pop   = !pop_n && !empty;
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  // head word always visible
  assign dout  = mem[rd_ptr];

  // wrap at DEPTH, not only at a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // the sequencer bounds outstanding reads to DEPTH
  a_no_overflow: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
    !push_n |-> !full);

  a_no_underflow: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
    !pop_n |-> !empty);

endmodule

`default_nettype wire

/* hw/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 32;
  // one chip-enable bit per register, register 0 on the top bit
  localparam int NUM_REGS   = 8;
  // one word per master command
  localparam int WORD_BYTES = 4;

  // register indices
  localparam int REG_SRC    = 0;
  localparam int REG_DST    = 1;
  localparam int REG_LEN    = 2;
  localparam int REG_GO     = 3;
  localparam int REG_STATUS = 4;
  localparam int REG_REMAIN = 5;

  // value that starts a transfer when written to REG_GO
  localparam logic [DATA_W-1:0] GO_KEY = 32'h0000_00cc;

  // status bit positions
  localparam int ST_BUSY       = 0;
  localparam int ST_DONE       = 1;
  localparam int ST_ERROR      = 2;
  localparam int ST_TIMEOUT    = 3;
  localparam int ST_FIFO_EMPTY = 4;
  localparam int ST_FIFO_FULL  = 5;

  // ------------------------------
  // state encodings
  // ------------------------------
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_RD_ISSUE,
    SEQ_RD_WAIT,
    SEQ_WR_ISSUE,
    SEQ_WR_WAIT
  } seq_state_e;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_RUN,
    CMD_WAIT_FOR_DATA,
    CMD_DONE
  } cmd_state_e;

endpackage

`default_nettype wire

/* hw/dma_regs.sv */
`default_nettype none
`timescale 1ns/10ps

module dma_regs import dma_pkg::*;
(
  input  logic                Bus2IP_Clk,
  input  logic                arst_n,
  input  logic [DATA_W-1:0]   bus2ip_data,
  input  logic [NUM_REGS-1:0] bus2ip_wrce,
  input  logic [NUM_REGS-1:0] bus2ip_rdce,
  input  logic                busy,
  input  logic                done,
  input  logic                err,
  input  logic                tmo,
  input  logic [DATA_W-1:0]   remain,
  input  logic                fifo_empty,
  input  logic                fifo_full,
  output logic [DATA_W-1:0]   ip2bus_data,
  output logic                ip2bus_wrack,
  output logic                ip2bus_rdack,
  output logic                start,
  output logic [ADDR_W-1:0]   src_addr,
  output logic [ADDR_W-1:0]   dst_addr,
  output logic [DATA_W-1:0]   len_bytes
);

  logic [NUM_REGS-1:0] wr_sel;
  logic [NUM_REGS-1:0] rd_sel;
  logic                done_q;
  logic                err_q;
  logic                tmo_q;
  logic [DATA_W-1:0]   status;

  // bit-reverse the enables so that index i selects register i
  assign wr_sel = {<<{bus2ip_wrce}};
  assign rd_sel = {<<{bus2ip_rdce}};

  // acks in the same cycle as the strobe
  assign ip2bus_wrack = |bus2ip_wrce;
  assign ip2bus_rdack = |bus2ip_rdce;

  // ------------------------------
  // programmed registers and go
  // ------------------------------
  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      src_addr  <= '0;
      dst_addr  <= '0;
      len_bytes <= '0;
      start     <= 1'b0;
    end
    else
    begin
      if (wr_sel[REG_SRC])
        src_addr <= bus2ip_data;
      if (wr_sel[REG_DST])
        dst_addr <= bus2ip_data;
      if (wr_sel[REG_LEN])
        len_bytes <= bus2ip_data;
      // go key accepted only when idle, one pulse per write
      start <= wr_sel[REG_GO] && (bus2ip_data == GO_KEY) && !busy && !start;
    end
  end

  // sticky completion flags, cleared by the next go
  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      tmo_q  <= 1'b0;
    end
    else if (start)
    begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      tmo_q  <= 1'b0;
    end
    else
    begin
      done_q <= done_q | done;
      err_q  <= err_q | err;
      tmo_q  <= tmo_q | tmo;
    end
  end

  always_comb
  begin
    status                = '0;
    status[ST_BUSY]       = busy;
    status[ST_DONE]       = done_q;
    status[ST_ERROR]      = err_q;
    status[ST_TIMEOUT]    = tmo_q;
    status[ST_FIFO_EMPTY] = fifo_empty;
    status[ST_FIFO_FULL]  = fifo_full;
  end

  // read mux, zero when no read strobe
  // go and the two spare indices read as zero
  always_comb
  begin
    ip2bus_data = '0;
    if (rd_sel[REG_SRC])
      ip2bus_data = src_addr;
    if (rd_sel[REG_DST])
      ip2bus_data = dst_addr;
    if (rd_sel[REG_LEN])
      ip2bus_data = len_bytes;
    if (rd_sel[REG_STATUS])
      ip2bus_data = status;
    if (rd_sel[REG_REMAIN])
      ip2bus_data = remain;
  end

endmodule

`default_nettype wire

/* hw/dma_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

module dma_sequencer import dma_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
)
(
  input  logic              Bus2IP_Clk,
  input  logic              arst_n,
  input  logic              start,
  input  logic [ADDR_W-1:0] src_addr,
  input  logic [ADDR_W-1:0] dst_addr,
  input  logic [DATA_W-1:0] len_bytes,
  input  logic              cmd_done,
  input  logic              cmd_err,
  input  logic              cmd_tmo,
  input  logic              fifo_empty,
  output logic              cmd_start,
  output logic              cmd_write,
  output logic [ADDR_W-1:0] cmd_addr,
  output logic              busy,
  output logic              done,
  output logic              err,
  output logic              tmo,
  output logic [DATA_W-1:0] remain,
  output logic              fifo_flush,
  output logic              irq
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  seq_state_e        state;
  seq_state_e        state_nxt;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] remain_q;
  // words read into the FIFO and not yet written out
  logic [CNT_W-1:0]  pending;
  logic              load;
  logic              rd_ok;
  logic              wr_ok;
  logic              last_rd;
  logic              abort;
  logic              finish;

  assign load    = (state == SEQ_IDLE) && start;
  assign rd_ok   = (state == SEQ_RD_WAIT) && cmd_done && !cmd_err;
  assign wr_ok   = (state == SEQ_WR_WAIT) && cmd_done && !cmd_err;
  assign abort   = cmd_done && cmd_err && (state == SEQ_RD_WAIT || state == SEQ_WR_WAIT);
  // read phase stops when the FIFO would be full or the length is used up
  assign last_rd = (pending == CNT_W'(FIFO_DEPTH - 1)) || (remain_q <= DATA_W'(WORD_BYTES));
  // zero length finishes straight from idle
  assign finish  = (load && len_bytes == '0) || (wr_ok && fifo_empty && remain_q == '0);

  assign busy      = (state != SEQ_IDLE);
  assign cmd_write = (state == SEQ_WR_ISSUE) || (state == SEQ_WR_WAIT);
  assign cmd_addr  = cmd_write ? dst_q : src_q;
  assign remain    = remain_q;

  // ------------------------------
  // phase sequencing
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      SEQ_IDLE:
        if (load && len_bytes != '0)
          state_nxt = SEQ_RD_ISSUE;
      SEQ_RD_ISSUE:
        state_nxt = SEQ_RD_WAIT;
      SEQ_RD_WAIT:
        if (abort)
          state_nxt = SEQ_IDLE;
        else if (rd_ok)
          state_nxt = last_rd ? SEQ_WR_ISSUE : SEQ_RD_ISSUE;
      SEQ_WR_ISSUE:
        state_nxt = SEQ_WR_WAIT;
      SEQ_WR_WAIT:
        if (abort || finish)
          state_nxt = SEQ_IDLE;
        else if (wr_ok)
          state_nxt = fifo_empty ? SEQ_RD_ISSUE : SEQ_WR_ISSUE;
      default:
        state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= SEQ_IDLE;
      cmd_start  <= 1'b0;
      done       <= 1'b0;
      irq        <= 1'b0;
      err        <= 1'b0;
      tmo        <= 1'b0;
      fifo_flush <= 1'b0;
      pending    <= '0;
      remain_q   <= '0;
    end
    else
    begin
      state      <= state_nxt;
      // one command per visit to an issue state
      cmd_start  <= (state_nxt == SEQ_RD_ISSUE) || (state_nxt == SEQ_WR_ISSUE);
      done       <= finish;
      irq        <= finish || abort;
      err        <= abort;
      tmo        <= abort && cmd_tmo;
      fifo_flush <= abort;
      if (load || (wr_ok && fifo_empty))
        pending <= '0;
      else if (rd_ok)
        pending <= pending + 1'b1;
      if (load)
        remain_q <= len_bytes;
      else if (rd_ok)
        remain_q <= last_rd && (remain_q <= DATA_W'(WORD_BYTES)) ? '0 :
                    remain_q - DATA_W'(WORD_BYTES);
    end
  end

  // working addresses
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (load)
    begin
      src_q <= src_addr;
      dst_q <= dst_addr;
    end
    else
    begin
      if (rd_ok)
        src_q <= src_q + ADDR_W'(WORD_BYTES);
      if (wr_ok)
        dst_q <= dst_q + ADDR_W'(WORD_BYTES);
    end
  end

  // a new read only goes out while the FIFO still has room for it
  a_pending_bound: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
    (state == SEQ_RD_ISSUE) |-> (pending < CNT_W'(FIFO_DEPTH)));

endmodule

`default_nettype wire

/* hw/mst_cmd_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

module mst_cmd_fsm import dma_pkg::*;
(
  input  logic              Bus2IP_Clk,
  input  logic              arst_n,
  input  logic              cmd_start,
  input  logic              cmd_write,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic              bus2ip_mst_cmdack,
  input  logic              bus2ip_mst_cmplt,
  input  logic              bus2ip_mst_error,
  input  logic              bus2ip_mst_cmd_timeout,
  output logic              ip2bus_mstrd_req,
  output logic              ip2bus_mstwr_req,
  output logic [ADDR_W-1:0] ip2bus_mst_addr,
  output logic              cmd_busy,
  output logic              cmd_done,
  output logic              cmd_err,
  output logic              cmd_tmo
);

  cmd_state_e state;
  logic       cmplt_seen;

  // completion only counts while a command is out
  assign cmplt_seen = bus2ip_mst_cmplt && (state == CMD_RUN || state == CMD_WAIT_FOR_DATA);

  // ------------------------------
  // command state machine
  // ------------------------------
  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state            <= CMD_IDLE;
      ip2bus_mstrd_req <= 1'b0;
      ip2bus_mstwr_req <= 1'b0;
      ip2bus_mst_addr  <= '0;
      cmd_busy         <= 1'b0;
      cmd_done         <= 1'b0;
    end
    else
    begin
      // request drops unless RUN keeps it up
      ip2bus_mstrd_req <= 1'b0;
      ip2bus_mstwr_req <= 1'b0;
      ip2bus_mst_addr  <= '0;
      cmd_done         <= 1'b0;
      cmd_busy         <= 1'b1;
      case (state)
        CMD_IDLE:
          if (cmd_start)
            state <= CMD_RUN;
          else
            cmd_busy <= 1'b0;
        CMD_RUN:
          if (bus2ip_mst_cmplt)
            state <= CMD_DONE;
          else if (bus2ip_mst_cmdack)
            state <= CMD_WAIT_FOR_DATA;
          else
          begin
            ip2bus_mstrd_req <= !cmd_write;
            ip2bus_mstwr_req <= cmd_write;
            ip2bus_mst_addr  <= cmd_addr;
          end
        CMD_WAIT_FOR_DATA:
          if (bus2ip_mst_cmplt)
            state <= CMD_DONE;
        CMD_DONE:
        begin
          // done pulses as the machine lands back in idle
          state    <= CMD_IDLE;
          cmd_done <= 1'b1;
          cmd_busy <= 1'b0;
        end
        default:
        begin
          state    <= CMD_IDLE;
          cmd_busy <= 1'b0;
        end
      endcase
    end
  end

  // response classification, held until the next command
  // timeout implies error
  always_ff @(posedge Bus2IP_Clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmd_err <= 1'b0;
      cmd_tmo <= 1'b0;
    end
    else if (cmd_start)
    begin
      cmd_err <= 1'b0;
      cmd_tmo <= 1'b0;
    end
    else if (cmplt_seen)
    begin
      cmd_err <= bus2ip_mst_cmd_timeout || bus2ip_mst_error;
      cmd_tmo <= bus2ip_mst_cmd_timeout;
    end
  end

  // direction and address stay put while a command is out on the bus
  a_cmd_held: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
    (state == CMD_RUN || state == CMD_WAIT_FOR_DATA) |->
      $stable(cmd_addr) && $stable(cmd_write));

  // the sequencer may only start a command into an idle machine
  a_start_when_idle: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
    cmd_start |-> (state == CMD_IDLE) && !cmd_busy);

endmodule

`default_nettype wire

/* hw/simple_dma.sv */
`default_nettype none
`timescale 1ns/10ps

module simple_dma import dma_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
)
(
  input  logic                Bus2IP_Clk,
  input  logic                arst_n,
  // register bus
  input  logic [DATA_W-1:0]   bus2ip_data,
  input  logic [NUM_REGS-1:0] bus2ip_wrce,
  input  logic [NUM_REGS-1:0] bus2ip_rdce,
  output logic [DATA_W-1:0]   ip2bus_data,
  output logic                ip2bus_wrack,
  output logic                ip2bus_rdack,
  // master command bus
  output logic                ip2bus_mstrd_req,
  output logic                ip2bus_mstwr_req,
  output logic [ADDR_W-1:0]   ip2bus_mst_addr,
  input  logic                bus2ip_mst_cmdack,
  input  logic                bus2ip_mst_cmplt,
  input  logic                bus2ip_mst_error,
  input  logic                bus2ip_mst_cmd_timeout,
  // master data
  input  logic [DATA_W-1:0]   bus2ip_mstrd_d,
  input  logic                bus2ip_mstrd_src_rdy_n,
  input  logic                bus2ip_mstwr_dst_rdy_n,
  output logic [DATA_W-1:0]   ip2bus_mstwr_d,
  output logic                irq
);

  logic              start;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic [DATA_W-1:0] len_bytes;
  logic              busy;
  logic              done;
  logic              err;
  logic              tmo;
  logic [DATA_W-1:0] remain;
  logic              fifo_empty;
  logic              fifo_full;
  logic              fifo_flush;
  logic              cmd_start;
  logic              cmd_write;
  logic [ADDR_W-1:0] cmd_addr;
  logic              cmd_done;
  logic              cmd_err;
  logic              cmd_tmo;

  // ------------------------------
  // input side
  // ------------------------------
  dma_regs u_regs (
    .Bus2IP_Clk   (Bus2IP_Clk),
    .arst_n       (arst_n),
    .bus2ip_data  (bus2ip_data),
    .bus2ip_wrce  (bus2ip_wrce),
    .bus2ip_rdce  (bus2ip_rdce),
    .busy         (busy),
    .done         (done),
    .err          (err),
    .tmo          (tmo),
    .remain       (remain),
    .fifo_empty   (fifo_empty),
    .fifo_full    (fifo_full),
    .ip2bus_data  (ip2bus_data),
    .ip2bus_wrack (ip2bus_wrack),
    .ip2bus_rdack (ip2bus_rdack),
    .start        (start),
    .src_addr     (src_addr),
    .dst_addr     (dst_addr),
    .len_bytes    (len_bytes)
  );

  // ------------------------------
  // processing
  // ------------------------------
  dma_sequencer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_seq (
    .Bus2IP_Clk (Bus2IP_Clk),
    .arst_n     (arst_n),
    .start      (start),
    .src_addr   (src_addr),
    .dst_addr   (dst_addr),
    .len_bytes  (len_bytes),
    .cmd_done   (cmd_done),
    .cmd_err    (cmd_err),
    .cmd_tmo    (cmd_tmo),
    .fifo_empty (fifo_empty),
    .cmd_start  (cmd_start),
    .cmd_write  (cmd_write),
    .cmd_addr   (cmd_addr),
    .busy       (busy),
    .done       (done),
    .err        (err),
    .tmo        (tmo),
    .remain     (remain),
    .fifo_flush (fifo_flush),
    .irq        (irq)
  );

  // busy flag of the command machine only feeds its own check
  mst_cmd_fsm u_cmd (
    .Bus2IP_Clk             (Bus2IP_Clk),
    .arst_n                 (arst_n),
    .cmd_start              (cmd_start),
    .cmd_write              (cmd_write),
    .cmd_addr               (cmd_addr),
    .bus2ip_mst_cmdack      (bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt       (bus2ip_mst_cmplt),
    .bus2ip_mst_error       (bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout (bus2ip_mst_cmd_timeout),
    .ip2bus_mstrd_req       (ip2bus_mstrd_req),
    .ip2bus_mstwr_req       (ip2bus_mstwr_req),
    .ip2bus_mst_addr        (ip2bus_mst_addr),
    .cmd_busy               (),
    .cmd_done               (cmd_done),
    .cmd_err                (cmd_err),
    .cmd_tmo                (cmd_tmo)
  );

  // ------------------------------
  // output side
  // ------------------------------
  data_fifo #(
    .DEPTH (FIFO_DEPTH),
    .WIDTH (DATA_W)
  ) u_fifo (
    .Bus2IP_Clk (Bus2IP_Clk),
    .arst_n     (arst_n),
    .flush      (fifo_flush),
    .push_n     (bus2ip_mstrd_src_rdy_n),
    .din        (bus2ip_mstrd_d),
    .pop_n      (bus2ip_mstwr_dst_rdy_n),
    .dout       (ip2bus_mstwr_d),
    .empty      (fifo_empty),
    .full       (fifo_full)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the simple_dma testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f files.f --top-module tb_simple_dma -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0
